// ==== common/spw_tx_pkg.sv ====
package spw_tx_pkg;

	// ------------------------------------------------------------
	// Host side types
	// ------------------------------------------------------------

	typedef logic [7:0] byte_t;

	// Flag on bit 8, with flag set bit 0 picks EOP or EEP
	typedef logic [8:0] nchar_t;

	// ------------------------------------------------------------
	// Character kinds and lengths
	// ------------------------------------------------------------

	typedef logic [2:0] char_kind_t;

	localparam char_kind_t KIND_NULL = 3'd0;
	localparam char_kind_t KIND_FCT  = 3'd1;
	localparam char_kind_t KIND_EOP  = 3'd2;
	localparam char_kind_t KIND_EEP  = 3'd3;
	localparam char_kind_t KIND_DATA = 3'd4;
	localparam char_kind_t KIND_TIME = 3'd5;

	typedef logic [3:0] bit_cnt_t;

	// Bits on the line, parity included
	localparam bit_cnt_t LEN_NULL = 4'd8;
	localparam bit_cnt_t LEN_FCT  = 4'd4;
	localparam bit_cnt_t LEN_EOP  = 4'd4;
	localparam bit_cnt_t LEN_DATA = 4'd10;
	localparam bit_cnt_t LEN_TIME = 4'd14;

	// ------------------------------------------------------------
	// Flow control
	// ------------------------------------------------------------

	typedef logic [5:0] credit_t;
	typedef logic [2:0] owed_t;

	// One FCT from the peer opens eight slots
	localparam credit_t CREDIT_STEP = 6'd8;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_NULL,
		ST_NULL_FCT,
		ST_RUN
	} link_state_t;

endpackage

// ==== common/char_if.sv ====
`timescale 1ns/1ns

interface char_if;

	import spw_tx_pkg::*;

	// Request side
	logic       start;
	char_kind_t kind;
	byte_t      payload;

	// Line side status
	logic       busy;
	logic       last;

	modport sched (
		output start,
		output kind,
		output payload,
		input  busy,
		input  last
	);

	modport ser (
		input  start,
		input  kind,
		input  payload,
		output busy,
		output last
	);

endinterface

// ==== src/credit_counter.sv ====
`timescale 1ns/1ns

module credit_counter #(
	parameter int CREDIT_MAX = 56,
	parameter int OWED_MAX   = 7
) (
	input  logic gotfct_tx,
	input  logic enable_tx,
	input  logic got_fct_i,
	input  logic rx_slot_free_i,
	input  logic fct_sent_i,
	input  logic nchar_sent_i,
	output logic has_credit_o,
	output logic fct_owed_o
);

	import spw_tx_pkg::*;

	credit_t credit_q;
	owed_t   owed_q;

	// One spare bit so the sum can pass the limit before clamping
	logic [$bits(credit_t):0] credit_sum;
	logic [$bits(owed_t):0]   owed_sum;

	logic credit_dec;
	logic owed_dec;

	assign credit_dec = nchar_sent_i && (credit_q != '0);
	assign owed_dec   = fct_sent_i && (owed_q != '0);

	always_comb
	begin
		credit_sum = {1'b0, credit_q};
		if (got_fct_i)
			credit_sum = credit_sum + {1'b0, CREDIT_STEP};
		credit_sum = credit_sum - {{$bits(credit_t){1'b0}}, credit_dec};

		owed_sum = {1'b0, owed_q} + {{$bits(owed_t){1'b0}}, rx_slot_free_i};
		owed_sum = owed_sum - {{$bits(owed_t){1'b0}}, owed_dec};
	end

	always_ff @(posedge gotfct_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			credit_q <= '0;
			owed_q   <= '0;
		end
		else
		begin
			if (int'(credit_sum) > CREDIT_MAX)
				credit_q <= credit_t'(CREDIT_MAX);
			else
				credit_q <= credit_t'(credit_sum);

			if (int'(owed_sum) > OWED_MAX)
				owed_q <= owed_t'(OWED_MAX);
			else
				owed_q <= owed_t'(owed_sum);
		end
	end

	// Levels leave out the character finishing this cycle
	assign has_credit_o = credit_q > {{($bits(credit_t) - 1){1'b0}}, nchar_sent_i};
	assign fct_owed_o   = owed_q > {{($bits(owed_t) - 1){1'b0}}, fct_sent_i};

endmodule

// ==== src/char_scheduler.sv ====
`timescale 1ns/1ns

module char_scheduler (
	input  logic               gotfct_tx,
	input  logic               enable_tx,
	input  logic               send_null_i,
	input  logic               send_fct_i,
	input  logic               tx_write_i,
	input  spw_tx_pkg::nchar_t tx_data_i,
	input  logic               tick_in_i,
	input  spw_tx_pkg::byte_t  time_in_i,
	input  logic               has_credit_i,
	input  logic               fct_owed_i,
	output logic               fct_sent_o,
	output logic               nchar_sent_o,
	output logic               data_ready_o,
	output logic               time_ready_o,
	char_if.sched              ch
);

	import spw_tx_pkg::*;

	link_state_t state_q;
	link_state_t state_d;

	char_kind_t  kind_q;
	char_kind_t  kind_d;
	byte_t       payload_d;
	logic        start_d;

	logic        tick_q;
	byte_t       time_q;

	logic        boundary;
	logic        data_ok;

	assign boundary = !ch.busy || ch.last;

	// No data right after data, the host still shows the old byte
	assign data_ok = tx_write_i && has_credit_i && !nchar_sent_o;

	// ------------------------------------------------------------
	// Link FSM and character choice
	// ------------------------------------------------------------

	always_comb
	begin
		state_d   = state_q;
		start_d   = 1'b0;
		kind_d    = KIND_NULL;
		payload_d = '0;

		case (state_q)
			ST_IDLE:
			begin
				if (send_null_i)
					state_d = ST_NULL;
			end
			ST_NULL:
			begin
				if (boundary)
				begin
					start_d = 1'b1;
					if (send_fct_i)
						state_d = ST_NULL_FCT;
				end
			end
			ST_NULL_FCT:
			begin
				if (boundary)
				begin
					start_d = 1'b1;
					if (fct_owed_i)
						kind_d = KIND_FCT;
					if (has_credit_i)
						state_d = ST_RUN;
				end
			end
			ST_RUN:
			begin
				if (boundary)
				begin
					start_d = 1'b1;
					if (tick_q)
					begin
						kind_d    = KIND_TIME;
						payload_d = time_q;
					end
					else if (fct_owed_i)
						kind_d = KIND_FCT;
					else if (data_ok)
					begin
						payload_d = tx_data_i[7:0];
						if (!tx_data_i[8])
							kind_d = KIND_DATA;
						else if (tx_data_i[0])
							kind_d = KIND_EEP;
						else
							kind_d = KIND_EOP;
					end
				end
			end
			default:
				state_d = ST_IDLE;
		endcase
	end

	assign ch.start   = start_d;
	assign ch.kind    = kind_d;
	assign ch.payload = payload_d;

	always_ff @(posedge gotfct_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			state_q <= ST_IDLE;
			kind_q  <= KIND_NULL;
			tick_q  <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			if (start_d)
				kind_q <= kind_d;
			if (tick_in_i)
				tick_q <= 1'b1;
			else if (start_d && kind_d == KIND_TIME)
				tick_q <= 1'b0;
		end
	end

	always_ff @(posedge gotfct_tx)
	begin
		if (tick_in_i)
			time_q <= time_in_i;
	end

	// Completion pulses on the final bit of the kind in flight
	assign fct_sent_o   = ch.last && kind_q == KIND_FCT;
	assign nchar_sent_o = ch.last && (kind_q == KIND_DATA || kind_q == KIND_EOP ||
	                                  kind_q == KIND_EEP);
	assign data_ready_o = nchar_sent_o;
	assign time_ready_o = ch.last && kind_q == KIND_TIME;

endmodule

// ==== char_encoder/char_serializer.sv ====
`timescale 1ns/1ns

module char_serializer (
	input  logic  gotfct_tx,
	input  logic  enable_tx,
	char_if.ser   ch,
	output logic  d_o,
	output logic  s_o
);

	import spw_tx_pkg::*;

	localparam logic [1:0] CODE_FCT = 2'b00;
	localparam logic [1:0] CODE_EOP = 2'b01;
	localparam logic [1:0] CODE_EEP = 2'b10;
	localparam logic [1:0] CODE_ESC = 2'b11;

	// Parity, flag, then two code bits in line order
	function automatic logic [3:0] ctrl_bits(input logic prev_par, input logic [1:0] code);
		ctrl_bits = {~(prev_par ^ 1'b1), 1'b1, code};
	endfunction

	// Parity, flag, then the byte LSB first
	function automatic logic [9:0] data_bits(input logic prev_par, input byte_t value);
		logic [9:0] bits;
		int         i;
		bits[9] = ~prev_par;
		bits[8] = 1'b0;
		for (i = 0; i < 8; i++)
			bits[7 - i] = value[i];
		return bits;
	endfunction

	logic [LEN_TIME-1:0] seq;
	logic [LEN_TIME-1:0] shift_q;
	bit_cnt_t            len;
	bit_cnt_t            cnt_q;
	logic                par_next;
	logic                prev_par_q;
	logic                busy_q;
	logic                d_q;
	logic                s_q;
	logic                adv;
	logic                d_next;

	// ------------------------------------------------------------
	// Character build
	// ------------------------------------------------------------

	always_comb
	begin
		seq      = '0;
		len      = LEN_NULL;
		par_next = 1'b0;

		case (ch.kind)
			KIND_FCT:
			begin
				seq[13:10] = ctrl_bits(prev_par_q, CODE_FCT);
				len        = LEN_FCT;
				par_next   = ^CODE_FCT;
			end
			KIND_EOP:
			begin
				seq[13:10] = ctrl_bits(prev_par_q, CODE_EOP);
				len        = LEN_EOP;
				par_next   = ^CODE_EOP;
			end
			KIND_EEP:
			begin
				seq[13:10] = ctrl_bits(prev_par_q, CODE_EEP);
				len        = LEN_EOP;
				par_next   = ^CODE_EEP;
			end
			KIND_DATA:
			begin
				seq[13:4] = data_bits(prev_par_q, ch.payload);
				len       = LEN_DATA;
				par_next  = ^ch.payload;
			end
			KIND_TIME:
			begin
				// Inner parity covers the ESC code bits
				seq[13:10] = ctrl_bits(prev_par_q, CODE_ESC);
				seq[9:0]   = data_bits(^CODE_ESC, ch.payload);
				len        = LEN_TIME;
				par_next   = ^ch.payload;
			end
			default:
			begin
				seq[13:10] = ctrl_bits(prev_par_q, CODE_ESC);
				seq[9:6]   = ctrl_bits(^CODE_ESC, CODE_FCT);
				len        = LEN_NULL;
				par_next   = ^CODE_FCT;
			end
		endcase
	end

	// ------------------------------------------------------------
	// Shifter and DS lines
	// ------------------------------------------------------------

	assign adv    = busy_q && cnt_q != '0;
	assign d_next = ch.start ? seq[LEN_TIME-1] : shift_q[LEN_TIME-1];

	always_ff @(posedge gotfct_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			busy_q     <= 1'b0;
			cnt_q      <= '0;
			prev_par_q <= 1'b0;
			d_q        <= 1'b0;
			s_q        <= 1'b0;
		end
		else
		begin
			if (ch.start)
			begin
				busy_q     <= 1'b1;
				cnt_q      <= len - 4'd1;
				prev_par_q <= par_next;
			end
			else if (adv)
				cnt_q <= cnt_q - 4'd1;
			else
				busy_q <= 1'b0;

			if (ch.start || adv)
			begin
				d_q <= d_next;
				// Strobe flips when data repeats
				if (d_next == d_q)
					s_q <= ~s_q;
			end
		end
	end

	always_ff @(posedge gotfct_tx)
	begin
		if (ch.start)
			shift_q <= seq << 1;
		else if (adv)
			shift_q <= shift_q << 1;
	end

	assign ch.busy = busy_q;
	assign ch.last = busy_q && cnt_q == '0;
	assign d_o     = d_q;
	assign s_o     = s_q;

endmodule

// ==== src/spw_tx.sv ====
`timescale 1ns/1ns

module spw_tx #(
	parameter int CREDIT_MAX = 56,
	parameter int OWED_MAX   = 7
) (
	input  logic                gotfct_tx,
	input  logic                enable_tx,
	input  logic                send_null_i,
	input  logic                send_fct_i,
	input  logic                tx_write_i,
	input  spw_tx_pkg::nchar_t  tx_data_i,
	input  logic                tick_in_i,
	input  spw_tx_pkg::byte_t   time_in_i,
	input  logic                got_fct_i,
	input  logic                rx_slot_free_i,
	output logic                d_o,
	output logic                s_o,
	output logic                data_ready_o,
	output logic                time_ready_o
);

	logic has_credit;
	logic fct_owed;
	logic fct_sent;
	logic nchar_sent;

	char_if ch ();

	credit_counter #(
		.CREDIT_MAX (CREDIT_MAX),
		.OWED_MAX   (OWED_MAX)
	) u_credit (
		.gotfct_tx      (gotfct_tx),
		.enable_tx      (enable_tx),
		.got_fct_i      (got_fct_i),
		.rx_slot_free_i (rx_slot_free_i),
		.fct_sent_i     (fct_sent),
		.nchar_sent_i   (nchar_sent),
		.has_credit_o   (has_credit),
		.fct_owed_o     (fct_owed)
	);

	char_scheduler u_sched (
		.gotfct_tx    (gotfct_tx),
		.enable_tx    (enable_tx),
		.send_null_i  (send_null_i),
		.send_fct_i   (send_fct_i),
		.tx_write_i   (tx_write_i),
		.tx_data_i    (tx_data_i),
		.tick_in_i    (tick_in_i),
		.time_in_i    (time_in_i),
		.has_credit_i (has_credit),
		.fct_owed_i   (fct_owed),
		.fct_sent_o   (fct_sent),
		.nchar_sent_o (nchar_sent),
		.data_ready_o (data_ready_o),
		.time_ready_o (time_ready_o),
		.ch           (ch.sched)
	);

	char_serializer u_ser (
		.gotfct_tx (gotfct_tx),
		.enable_tx (enable_tx),
		.ch        (ch.ser),
		.d_o       (d_o),
		.s_o       (s_o)
	);

endmodule

// ==== testbench/spw_tx_assert.sv ====
`timescale 1ns/1ns

module spw_tx_assert (
	input logic gotfct_tx,
	input logic enable_tx,
	input logic send_null_i,
	input logic d_o,
	input logic s_o,
	input logic data_ready_o,
	input logic time_ready_o
);

	logic null_seen_q;
	logic line_up_q;
	int   fail_cnt = 0;

	always_ff @(posedge gotfct_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			null_seen_q <= 1'b0;
			line_up_q   <= 1'b0;
		end
		else
		begin
			if (send_null_i)
				null_seen_q <= 1'b1;
			if (s_o || d_o)
				line_up_q <= 1'b1;
		end
	end

	// One DS line moves per bit
	a_one_edge: assert property (@(posedge gotfct_tx) disable iff (!enable_tx)
		line_up_q |=> ((d_o ^ $past(d_o)) ^ (s_o ^ $past(s_o))))
		else
		begin
			fail_cnt++;
			$error("d_o and s_o did not change one at a time");
		end

	a_data_ready: assert property (@(posedge gotfct_tx) disable iff (!enable_tx)
		data_ready_o |=> !data_ready_o)
		else
		begin
			fail_cnt++;
			$error("data_ready_o longer than one cycle");
		end

	a_time_ready: assert property (@(posedge gotfct_tx) disable iff (!enable_tx)
		time_ready_o |=> !time_ready_o)
		else
		begin
			fail_cnt++;
			$error("time_ready_o longer than one cycle");
		end

	a_quiet: assert property (@(posedge gotfct_tx) disable iff (!enable_tx)
		!null_seen_q |-> (!d_o && !s_o))
		else
		begin
			fail_cnt++;
			$error("line active before send_null_i");
		end

endmodule

bind spw_tx spw_tx_assert u_assert (.*);

// ==== testbench/tb_spw_tx.sv ====
`timescale 1ns/1ns

module tb_spw_tx;

	import spw_tx_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DLY  = 5;
	// Line bits over all tests including NULL fill and idle waits
	localparam int TEST_BITS  = 8 + 48 + 96 + 200 + 80 + 60;

	logic   gotfct_tx;
	logic   enable_tx;
	logic   send_null_i;
	logic   send_fct_i;
	logic   tx_write_i;
	nchar_t tx_data_i;
	logic   tick_in_i;
	byte_t  time_in_i;
	logic   got_fct_i;
	logic   rx_slot_free_i;
	logic   d_o;
	logic   s_o;
	logic   data_ready_o;
	logic   time_ready_o;

	logic       line_bits[$];
	char_kind_t rx_kind[$];
	byte_t      rx_val[$];
	logic [7:0] first_bits;
	int         bit_total;
	logic       started;
	int         data_seen;
	int         data_ready_cnt;
	int         time_ready_cnt;
	int         parity_checks;
	int         checks;
	int         errors;
	logic [31:0] rng;

	spw_tx #(
		.CREDIT_MAX (56),
		.OWED_MAX   (7)
	) dut (
		.gotfct_tx      (gotfct_tx),
		.enable_tx      (enable_tx),
		.send_null_i    (send_null_i),
		.send_fct_i     (send_fct_i),
		.tx_write_i     (tx_write_i),
		.tx_data_i      (tx_data_i),
		.tick_in_i      (tick_in_i),
		.time_in_i      (time_in_i),
		.got_fct_i      (got_fct_i),
		.rx_slot_free_i (rx_slot_free_i),
		.d_o            (d_o),
		.s_o            (s_o),
		.data_ready_o   (data_ready_o),
		.time_ready_o   (time_ready_o)
	);

	initial
	begin
		gotfct_tx = 1'b0;
		forever
			#(CLK_PERIOD / 2) gotfct_tx = ~gotfct_tx;
	end

	// Odd parity over previous payload, flag and parity bit
	function automatic logic expected_parity(input logic prev_xor, input logic flag);
		return ~(prev_xor ^ flag);
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_equal(input string name, input int expected, input int actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("[ERROR] %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	// ------------------------------------------------------------
	// DS decoder
	// ------------------------------------------------------------

	always @(negedge gotfct_tx)
	begin
		if (enable_tx && !started && (d_o || s_o))
			started = 1'b1;
		if (started)
		begin
			if (bit_total < 8)
				first_bits[7 - bit_total] = d_o;
			bit_total++;
			line_bits.push_back(d_o);
		end
		if (data_ready_o)
			data_ready_cnt++;
		if (time_ready_o)
			time_ready_cnt++;
	end

	task automatic next_bit(output logic b);
		while (line_bits.size() == 0)
			@(negedge gotfct_tx);
		b = line_bits.pop_front();
	endtask

	task automatic read_byte(output byte_t v);
		logic b;
		for (int i = 0; i < 8; i++)
		begin
			next_bit(b);
			v[i] = b;
		end
	endtask

	initial
	begin : parser
		logic       p;
		logic       f;
		logic       c1;
		logic       c0;
		logic       prev_xor;
		byte_t      v;
		char_kind_t k;
		prev_xor = 1'b0;
		forever
		begin
			v = '0;
			next_bit(p);
			next_bit(f);
			parity_checks++;
			check_equal("parity", expected_parity(prev_xor, f), p);
			if (f)
			begin
				next_bit(c1);
				next_bit(c0);
				prev_xor = c1 ^ c0;
				if ({c1, c0} == 2'b11)
				begin
					next_bit(p);
					next_bit(f);
					parity_checks++;
					check_equal("esc parity", expected_parity(prev_xor, f), p);
					if (f)
					begin
						next_bit(c1);
						next_bit(c0);
						check_equal("null code", 0, {c1, c0});
						prev_xor = c1 ^ c0;
						k = KIND_NULL;
					end
					else
					begin
						read_byte(v);
						prev_xor = ^v;
						k = KIND_TIME;
					end
				end
				else if ({c1, c0} == 2'b00)
					k = KIND_FCT;
				else if ({c1, c0} == 2'b01)
					k = KIND_EOP;
				else
					k = KIND_EEP;
			end
			else
			begin
				read_byte(v);
				prev_xor = ^v;
				k = KIND_DATA;
				data_seen++;
			end
			rx_kind.push_back(k);
			rx_val.push_back(v);
		end
	end

	task automatic pull_char(output char_kind_t k, output byte_t v);
		while (rx_kind.size() == 0)
			@(negedge gotfct_tx);
		k = rx_kind.pop_front();
		v = rx_val.pop_front();
	endtask

	task automatic pull_skip_null(output char_kind_t k, output byte_t v);
		k = KIND_NULL;
		while (k == KIND_NULL)
			pull_char(k, v);
	endtask

	task automatic flush_chars();
		rx_kind.delete();
		rx_val.delete();
	endtask

	task automatic cycles(input int n);
		repeat (n) @(posedge gotfct_tx);
		#DRIVE_DLY;
	endtask

	task automatic wait_data_ready();
		int target;
		target = data_ready_cnt + 1;
		while (data_ready_cnt < target)
			@(negedge gotfct_tx);
		cycles(1);
	endtask

	task automatic report(input string name, input int err_before);
		$display("%s: %0d errors", name, errors - err_before);
	endtask

	// ------------------------------------------------------------
	// Watchdog
	// ------------------------------------------------------------

	initial
	begin
		#(TEST_BITS * CLK_PERIOD * 3);
		$display("Watchdog expired before all tests finished");
		$display("Test failed");
		$finish;
	end

	// ------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------

	initial
	begin : main
		char_kind_t k;
		byte_t      v;
		byte_t      sent[$];
		int         e0;
		int         fct_cnt;
		int         null_cnt;
		int         seen_before;
		int         ready_before;
		nchar_t     ninth;
		byte_t      tval;
		byte_t      dval;

		enable_tx = 1'b0;
		send_null_i = 1'b0;
		send_fct_i = 1'b0;
		tx_write_i = 1'b0;
		tx_data_i = '0;
		tick_in_i = 1'b0;
		time_in_i = '0;
		got_fct_i = 1'b0;
		rx_slot_free_i = 1'b0;
		started = 1'b0;
		bit_total = 0;
		first_bits = '0;
		data_seen = 0;
		data_ready_cnt = 0;
		time_ready_cnt = 0;
		parity_checks = 0;
		checks = 0;
		errors = 0;
		rng = 32'd22;

		cycles(8);
		enable_tx = 1'b1;
		cycles(4);

		// 1. NULLs only after send_null
		e0 = errors;
		send_null_i = 1'b1;
		cycles(1);
		send_null_i = 1'b0;
		null_cnt = 0;
		for (int i = 0; i < 6; i++)
		begin
			pull_char(k, v);
			if (k == KIND_NULL)
				null_cnt++;
		end
		check_equal("null only", 6, null_cnt);
		check_equal("first bits", 8'b0111_0100, first_bits);
		report("null start", e0);

		// 2. Owed FCTs and data held back without credit
		e0 = errors;
		cycles(1);
		flush_chars();
		rng = xorshift(rng);
		tx_write_i = 1'b1;
		tx_data_i = {1'b0, rng[7:0]};
		send_fct_i = 1'b1;
		for (int i = 0; i < 3; i++)
		begin
			rx_slot_free_i = 1'b1;
			cycles(1);
			rx_slot_free_i = 1'b0;
			cycles(1);
		end
		fct_cnt = 0;
		for (int i = 0; i < 12; i++)
		begin
			pull_char(k, v);
			if (k == KIND_FCT)
				fct_cnt++;
		end
		check_equal("fct count", 3, fct_cnt);
		check_equal("last char null", KIND_NULL, k);
		check_equal("no data", 0, data_seen);
		report("owed fct", e0);

		// 3. One FCT from the peer gives eight data slots
		e0 = errors;
		flush_chars();
		cycles(30);
		check_equal("data without credit", 0, data_seen);
		got_fct_i = 1'b1;
		cycles(1);
		got_fct_i = 1'b0;
		sent.push_back(tx_data_i[7:0]);
		for (int i = 0; i < 8; i++)
		begin
			wait_data_ready();
			rng = xorshift(rng);
			tx_data_i = {1'b0, rng[7:0]};
			if (i < 7)
				sent.push_back(rng[7:0]);
		end
		ninth = tx_data_i;
		for (int i = 0; i < 8; i++)
		begin
			pull_skip_null(k, v);
			check_equal("data kind", KIND_DATA, k);
			check_equal("data byte", sent[i], v);
		end
		check_equal("ready pulses", 8, data_ready_cnt);
		seen_before = data_seen;
		ready_before = data_ready_cnt;
		cycles(40);
		check_equal("ninth waits", seen_before, data_seen);
		check_equal("no ready", ready_before, data_ready_cnt);
		report("credit data", e0);

		// 4. EOP and EEP from flagged host characters
		e0 = errors;
		got_fct_i = 1'b1;
		cycles(1);
		got_fct_i = 1'b0;
		wait_data_ready();
		tx_data_i = 9'h100;
		wait_data_ready();
		tx_data_i = 9'h101;
		wait_data_ready();
		tx_write_i = 1'b0;
		pull_skip_null(k, v);
		check_equal("ninth kind", KIND_DATA, k);
		check_equal("ninth byte", ninth[7:0], v);
		pull_skip_null(k, v);
		check_equal("eop kind", KIND_EOP, k);
		pull_skip_null(k, v);
		check_equal("eep kind", KIND_EEP, k);
		report("eop eep", e0);

		// 5. Latched tick goes ahead of pending data
		e0 = errors;
		cycles(1);
		rng = xorshift(rng);
		tval = rng[7:0];
		rng = xorshift(rng);
		dval = rng[7:0];
		tick_in_i = 1'b1;
		time_in_i = tval;
		cycles(1);
		tick_in_i = 1'b0;
		tx_write_i = 1'b1;
		tx_data_i = {1'b0, dval};
		wait_data_ready();
		tx_write_i = 1'b0;
		check_equal("time ready", 1, time_ready_cnt);
		pull_skip_null(k, v);
		check_equal("time kind", KIND_TIME, k);
		check_equal("time value", tval, v);
		pull_skip_null(k, v);
		check_equal("after time kind", KIND_DATA, k);
		check_equal("after time byte", dval, v);
		report("time code", e0);

		// 6. Parity was checked on every decoded character
		$display("parity: %0d characters checked", parity_checks);

		errors += dut.u_assert.fail_cnt;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== spw_tx.f ====
common/spw_tx_pkg.sv
common/char_if.sv
src/credit_counter.sv
src/char_scheduler.sv
char_encoder/char_serializer.sv
src/spw_tx.sv
testbench/spw_tx_assert.sv
testbench/tb_spw_tx.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the SpaceWire transmitter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
	--top-module tb_spw_tx -f spw_tx.f -o sim_tb_spw_tx

out=$(./obj_dir/sim_tb_spw_tx)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
	exit 0
else
	exit 1
fi
